//--- rtl/dcache_rd_port.sv
module dcache_rd_port
    import wb_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rd_start_i,
    input  logic [XLEN-1:0] rd_addr_i,
    input  logic            m_arready_i,
    input  logic [XLEN-1:0] m_rdata_i,
    input  logic [1:0]      m_rresp_i,
    input  logic            m_rvalid_i,
    output logic [XLEN-1:0] m_araddr_o,
    output logic            m_arvalid_o,
    output logic            m_rready_o,
    output logic            rd_busy_o,
    output logic [XLEN-1:0] rd_data_o,
    output logic            rd_valid_o,
    output logic            rd_err_o
);

    logic            ar_q;
    logic            r_q;
    logic [XLEN-1:0] addr_q;
    logic            beat;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_q <= 1'b0;
            r_q  <= 1'b0;
        end else begin
            if (rd_start_i) begin
                ar_q <= 1'b1;
            end else if (m_arready_i) begin
                ar_q <= 1'b0;
            end
            if (ar_q && m_arready_i) begin
                r_q <= 1'b1;
            end else if (beat) begin
                r_q <= 1'b0;
            end
        end
    end

    // word aligned, lanes are picked later in wb_stage
    always_ff @(posedge clk) begin
        if (rd_start_i) begin
            addr_q <= {rd_addr_i[XLEN-1:2], 2'b00};
        end
    end

    assign m_araddr_o  = addr_q;
    assign m_arvalid_o = ar_q;
    assign m_rready_o  = r_q;
    assign rd_busy_o   = ar_q || r_q;

    assign beat       = r_q && m_rvalid_i;
    assign rd_data_o  = m_rdata_i;
    assign rd_valid_o = beat && (m_rresp_i == 2'b00);
    assign rd_err_o   = beat && (m_rresp_i != 2'b00);

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

endmodule

//--- rtl/mem_wb_reg.sv
module mem_wb_reg
    import wb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               take_i,
    input  logic               clear_i,
    input  logic [XLEN-1:0]    op_c_i,
    input  logic [RADDR_W-1:0] op_waddr_i,
    input  logic               op_we_i,
    input  logic               op_load_i,
    input  logic [2:0]         op_width_i,
    output logic [XLEN-1:0]    memwb_op_c_o,
    output logic [RADDR_W-1:0] memwb_waddr_o,
    output logic               memwb_we_o,
    output logic               memwb_load_o,
    output logic [2:0]         memwb_width_o,
    output logic               memwb_valid_o
);

    logic we_q;
    logic valid_q;

    // occupancy, take wins over clear when a new op replaces a retiring one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (take_i) begin
            valid_q <= 1'b1;
        end else if (clear_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_i) begin
            memwb_op_c_o  <= op_c_i;
            memwb_waddr_o <= op_waddr_i;
            we_q          <= op_we_i;
            memwb_load_o  <= op_load_i;
            memwb_width_o <= op_width_i;
        end
    end

    assign memwb_we_o    = we_q && valid_q;
    assign memwb_valid_o = valid_q;

endmodule

//--- rtl/rd_wait_timer.sv
module rd_wait_timer #(
    parameter int TIMEOUT = 16
) (
    input  logic clk,
    input  logic rst_n,
    input  logic rd_busy_i,
    output logic rd_slow_o
);

    localparam int CNT_W = $clog2(TIMEOUT + 2);

    logic [CNT_W-1:0] cnt_q;

    // stops one past TIMEOUT so the flag fires once per read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (!rd_busy_i) begin
            cnt_q <= '0;
        end else if (cnt_q <= CNT_W'(TIMEOUT)) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign rd_slow_o = rd_busy_i && (cnt_q == CNT_W'(TIMEOUT));

endmodule

//--- rtl/wb_flow_ctrl.sv
module wb_flow_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic op_valid_i,
    input  logic op_load_i,
    input  logic stall_i,
    input  logic memwb_valid_i,
    input  logic memwb_load_i,
    input  logic rd_valid_i,
    input  logic rd_err_i,
    output logic op_ready_o,
    output logic take_o,
    output logic clear_o,
    output logic rd_start_o,
    output logic bk_wb_o,
    output logic flush_wb_o,
    output logic load_err_o
);

    typedef enum logic [1:0] {
        EMPTY     = 2'd0,
        HOLD_ALU  = 2'd1,
        WAIT_RD   = 2'd2,
        HOLD_LOAD = 2'd3
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   run_q;
    logic   retire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= EMPTY;
            run_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            run_q   <= 1'b1;
        end
    end

    // held op is written this cycle unless the front end stalls
    assign retire     = (state_q == HOLD_ALU || state_q == HOLD_LOAD) && !stall_i;
    assign op_ready_o = run_q && (!memwb_valid_i || retire);
    assign take_o     = op_valid_i && op_ready_o;
    assign rd_start_o = take_o && op_load_i;

    assign bk_wb_o    = stall_i;
    assign flush_wb_o = rd_err_i;
    assign load_err_o = rd_err_i;

    always_comb begin
        state_d = state_q;
        clear_o = 1'b0;
        case (state_q)
            EMPTY, HOLD_ALU, HOLD_LOAD: begin
                if (take_o) begin
                    state_d = op_load_i ? WAIT_RD : HOLD_ALU;
                end else if (retire) begin
                    state_d = EMPTY;
                    clear_o = 1'b1;
                end
            end
            WAIT_RD: begin
                if (rd_err_i) begin
                    state_d = EMPTY;
                    clear_o = 1'b1;
                end else if (rd_valid_i) begin
                    // word goes to the keep buffer if stalled
                    state_d = stall_i ? HOLD_LOAD : EMPTY;
                    clear_o = !stall_i;
                end
            end
            default: state_d = EMPTY;
        endcase
    end

    a_no_start_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == WAIT_RD |-> !rd_start_o && !op_ready_o);

    // the register must still hold the load while its read is out
    a_wait_holds_load: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == WAIT_RD |-> memwb_valid_i && memwb_load_i);

endmodule

//--- rtl/wb_pkg.sv
package wb_pkg;

    localparam int XLEN    = 32;
    localparam int RADDR_W = 5;

    // low two bits of the op width field
    typedef enum logic [1:0] {
        WIDTH_B = 2'b00,
        WIDTH_H = 2'b01,
        WIDTH_W = 2'b10
    } width_e;

    // bit 2 of the op width field, set for lbu/lhu
    localparam int WIDTH_UNS_BIT = 2;

    // returned load word, seen as byte lanes or half lanes
    typedef union packed {
        logic [XLEN/8-1:0][7:0]   b;
        logic [XLEN/16-1:0][15:0] h;
    } load_word_t;

endpackage

//--- rtl/wb_stage.sv
module wb_stage
    import wb_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [XLEN-1:0]    memwb_op_c_i,
    input  logic [RADDR_W-1:0] memwb_waddr_i,
    input  logic               memwb_we_i,
    input  logic               memwb_load_i,
    input  logic [2:0]         memwb_width_i,
    input  logic [XLEN-1:0]    rd_data_i,
    input  logic               rd_valid_i,
    input  logic               bk_wb_i,
    input  logic               flush_wb_i,
    output logic [XLEN-1:0]    wb_data_o,
    output logic [RADDR_W-1:0] wb_waddr_o,
    output logic               wb_we_o
);

    load_word_t      buf_q;
    logic            buf_full_q;
    load_word_t      word;
    logic [1:0]      lane;
    logic            sext;
    logic [XLEN-1:0] load_val;
    logic            load_done;

    // keep takes priority over flush
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_full_q <= 1'b0;
        end else if (bk_wb_i && rd_valid_i) begin
            buf_full_q <= 1'b1;
        end else if (flush_wb_i || !bk_wb_i) begin
            buf_full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bk_wb_i && rd_valid_i) begin
            buf_q <= rd_data_i;
        end
    end

    assign lane = memwb_op_c_i[1:0];
    assign sext = !memwb_width_i[WIDTH_UNS_BIT];

    always_comb begin
        word = buf_full_q ? buf_q : rd_data_i;
        case (width_e'(memwb_width_i[1:0]))
            WIDTH_B: load_val = {{(XLEN-8){sext && word.b[lane][7]}}, word.b[lane]};
            WIDTH_H: load_val = {{(XLEN-16){sext && word.h[lane[1]][15]}}, word.h[lane[1]]};
            default: load_val = word;
        endcase
    end

    // a load writes on its live beat or from the buffer after the stall
    assign load_done = rd_valid_i || buf_full_q;

    assign wb_data_o  = memwb_load_i ? load_val : memwb_op_c_i;
    assign wb_waddr_o = memwb_waddr_i;
    assign wb_we_o    = memwb_we_i && !bk_wb_i && !flush_wb_i
                        && (!memwb_load_i || load_done);

endmodule

//--- rtl/wb_subsys_top.sv
module wb_subsys_top
    import wb_pkg::*;
#(
    parameter int TIMEOUT = 16
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               op_valid_i,
    output logic               op_ready_o,
    input  logic [XLEN-1:0]    op_c_i,
    input  logic [RADDR_W-1:0] op_waddr_i,
    input  logic               op_we_i,
    input  logic               op_load_i,
    input  logic [2:0]         op_width_i,
    output logic [XLEN-1:0]    m_araddr_o,
    output logic               m_arvalid_o,
    input  logic               m_arready_i,
    input  logic [XLEN-1:0]    m_rdata_i,
    input  logic [1:0]         m_rresp_i,
    input  logic               m_rvalid_i,
    output logic               m_rready_o,
    output logic               wb_we_o,
    output logic [RADDR_W-1:0] wb_waddr_o,
    output logic [XLEN-1:0]    wb_data_o,
    output logic               load_err_o,
    output logic               rd_slow_o,
    input  logic               stall_i
);

    logic               take;
    logic               clear;
    logic               rd_start;
    logic               bk_wb;
    logic               flush_wb;
    logic [XLEN-1:0]    memwb_op_c;
    logic [RADDR_W-1:0] memwb_waddr;
    logic               memwb_we;
    logic               memwb_load;
    logic [2:0]         memwb_width;
    logic               memwb_valid;
    logic [XLEN-1:0]    rd_data;
    logic               rd_valid;
    logic               rd_err;
    logic               rd_busy;

    mem_wb_reg u_mem_wb_reg (
        .clk           (clk),
        .rst_n         (rst_n),
        .take_i        (take),
        .clear_i       (clear),
        .op_c_i        (op_c_i),
        .op_waddr_i    (op_waddr_i),
        .op_we_i       (op_we_i),
        .op_load_i     (op_load_i),
        .op_width_i    (op_width_i),
        .memwb_op_c_o  (memwb_op_c),
        .memwb_waddr_o (memwb_waddr),
        .memwb_we_o    (memwb_we),
        .memwb_load_o  (memwb_load),
        .memwb_width_o (memwb_width),
        .memwb_valid_o (memwb_valid)
    );

    wb_flow_ctrl u_wb_flow_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_valid_i    (op_valid_i),
        .op_load_i     (op_load_i),
        .stall_i       (stall_i),
        .memwb_valid_i (memwb_valid),
        .memwb_load_i  (memwb_load),
        .rd_valid_i    (rd_valid),
        .rd_err_i      (rd_err),
        .op_ready_o    (op_ready_o),
        .take_o        (take),
        .clear_o       (clear),
        .rd_start_o    (rd_start),
        .bk_wb_o       (bk_wb),
        .flush_wb_o    (flush_wb),
        .load_err_o    (load_err_o)
    );

    rd_wait_timer #(
        .TIMEOUT (TIMEOUT)
    ) u_rd_wait_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_busy_i (rd_busy),
        .rd_slow_o (rd_slow_o)
    );

    dcache_rd_port u_dcache_rd_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_start_i  (rd_start),
        .rd_addr_i   (op_c_i),
        .m_arready_i (m_arready_i),
        .m_rdata_i   (m_rdata_i),
        .m_rresp_i   (m_rresp_i),
        .m_rvalid_i  (m_rvalid_i),
        .m_araddr_o  (m_araddr_o),
        .m_arvalid_o (m_arvalid_o),
        .m_rready_o  (m_rready_o),
        .rd_busy_o   (rd_busy),
        .rd_data_o   (rd_data),
        .rd_valid_o  (rd_valid),
        .rd_err_o    (rd_err)
    );

    wb_stage u_wb_stage (
        .clk           (clk),
        .rst_n         (rst_n),
        .memwb_op_c_i  (memwb_op_c),
        .memwb_waddr_i (memwb_waddr),
        .memwb_we_i    (memwb_we),
        .memwb_load_i  (memwb_load),
        .memwb_width_i (memwb_width),
        .rd_data_i     (rd_data),
        .rd_valid_i    (rd_valid),
        .bk_wb_i       (bk_wb),
        .flush_wb_i    (flush_wb),
        .wb_data_o     (wb_data_o),
        .wb_waddr_o    (wb_waddr_o),
        .wb_we_o       (wb_we_o)
    );

endmodule

//--- tb/axil_mem_model.sv
module axil_mem_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  logic [2:0]  ar_wait_i,
    input  logic [4:0]  r_wait_i,
    input  logic        err_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [1:0]  phase_q;
    logic [4:0]  cnt_q;
    logic [4:0]  r_wait_q;
    logic        err_q;
    logic [31:0] addr_q;

    // every word is mixed from its full address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1_e995;
    endfunction

    // phase 0 idle, 1 delaying arready, 2 delaying the R beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q   <= 2'd0;
            cnt_q     <= '0;
            r_wait_q  <= '0;
            err_q     <= 1'b0;
            addr_q    <= '0;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
            rresp_o   <= 2'b00;
            rdata_o   <= '0;
        end else begin
            arready_o <= 1'b0;
            case (phase_q)
                2'd0: begin
                    if (arvalid_i) begin
                        cnt_q    <= {2'b00, ar_wait_i};
                        r_wait_q <= r_wait_i;
                        err_q    <= err_i;
                        phase_q  <= 2'd1;
                    end
                end
                2'd1: begin
                    if (cnt_q == 0) begin
                        arready_o <= 1'b1;
                        addr_q    <= araddr_i;
                        cnt_q     <= r_wait_q;
                        phase_q   <= 2'd2;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    if (rvalid_o && rready_i) begin
                        rvalid_o <= 1'b0;
                        phase_q  <= 2'd0;
                    end else if (!rvalid_o && cnt_q == 0) begin
                        rvalid_o <= 1'b1;
                        rdata_o  <= fill_word(addr_q);
                        rresp_o  <= err_q ? 2'b10 : 2'b00;
                    end else if (!rvalid_o) begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

//--- tb/tb_wb_subsys.sv
module tb_wb_subsys
    import wb_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT = 16;
    localparam int          NUM_OPS = 600;
    localparam int          ALU_OPS = 150;
    localparam int          LONG_AT = 400;
    localparam logic [31:0] SEED    = 32'h24d1;

    logic               clk;
    logic               rst_n;
    logic               op_valid;
    logic               op_ready;
    logic [XLEN-1:0]    op_c;
    logic [RADDR_W-1:0] op_waddr;
    logic               op_we;
    logic               op_load;
    logic [2:0]         op_width;
    logic [XLEN-1:0]    m_araddr;
    logic               m_arvalid;
    logic               m_arready;
    logic [XLEN-1:0]    m_rdata;
    logic [1:0]         m_rresp;
    logic               m_rvalid;
    logic               m_rready;
    logic               wb_we;
    logic [RADDR_W-1:0] wb_waddr;
    logic [XLEN-1:0]    wb_data;
    logic               load_err;
    logic               rd_slow;
    logic               stall      = 1'b0;
    logic [2:0]         ar_wait    = '0;
    logic [4:0]         r_wait     = '0;
    logic               inject_err = 1'b0;
    logic               long_lat   = 1'b0;
    logic               err_en     = 1'b0;
    logic               stall_en   = 1'b0;

    logic [31:0] op_rng  = SEED;
    logic [31:0] env_rng = ~SEED;
    int          stall_left = 0;

    // expected writes as {waddr, data} in acceptance order
    logic [RADDR_W+XLEN-1:0] exp_q[$];
    logic                    pend_load = 1'b0;
    logic [XLEN-1:0]         pend_addr;
    logic [2:0]              pend_width;
    logic                    pend_we;
    logic [RADDR_W-1:0]      pend_waddr;
    int err_cnt   = 0;
    int checked   = 0;
    int err_exp   = 0;
    int err_seen  = 0;
    int slow_exp  = 0;
    int slow_seen = 0;
    int wait_cnt  = 0;

    wb_subsys_top #(
        .TIMEOUT (TIMEOUT)
    ) u_wb_subsys_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid_i  (op_valid),
        .op_ready_o  (op_ready),
        .op_c_i      (op_c),
        .op_waddr_i  (op_waddr),
        .op_we_i     (op_we),
        .op_load_i   (op_load),
        .op_width_i  (op_width),
        .m_araddr_o  (m_araddr),
        .m_arvalid_o (m_arvalid),
        .m_arready_i (m_arready),
        .m_rdata_i   (m_rdata),
        .m_rresp_i   (m_rresp),
        .m_rvalid_i  (m_rvalid),
        .m_rready_o  (m_rready),
        .wb_we_o     (wb_we),
        .wb_waddr_o  (wb_waddr),
        .wb_data_o   (wb_data),
        .load_err_o  (load_err),
        .rd_slow_o   (rd_slow),
        .stall_i     (stall)
    );

    axil_mem_model u_axil_mem_model (
        .clk       (clk),
        .rst_n     (rst_n),
        .araddr_i  (m_araddr),
        .arvalid_i (m_arvalid),
        .arready_o (m_arready),
        .rdata_o   (m_rdata),
        .rresp_o   (m_rresp),
        .rvalid_o  (m_rvalid),
        .rready_i  (m_rready),
        .ar_wait_i (ar_wait),
        .r_wait_i  (r_wait),
        .err_i     (inject_err)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // same fill rule as the memory model
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [XLEN-1:0] extract_load(input logic [XLEN-1:0] w,
                                                    input logic [1:0] off,
                                                    input logic [2:0] width);
        logic [XLEN-1:0] v;
        v = w;
        if (width[1:0] == WIDTH_B) begin
            v = (w >> (8 * off)) & 32'h0000_00ff;
            if (!width[2] && v[7]) begin
                v = v | 32'hffff_ff00;
            end
        end else if (width[1:0] == WIDTH_H) begin
            v = (w >> (16 * off[1])) & 32'h0000_ffff;
            if (!width[2] && v[15]) begin
                v = v | 32'hffff_0000;
            end
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        err_cnt++;
        $display("CHECK FAILED @%0t: %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("errors=%0d writes=%0d load_errs=%0d/%0d slow_reads=%0d/%0d",
                 err_cnt, checked, err_seen, err_exp, slow_seen, slow_exp);
    endtask

    task automatic send_op(input logic [XLEN-1:0] c, input logic [RADDR_W-1:0] waddr,
                           input logic we, input logic load, input logic [2:0] width);
        op_valid <= 1'b1;
        op_c     <= c;
        op_waddr <= waddr;
        op_we    <= we;
        op_load  <= load;
        op_width <= width;
        @(posedge clk);
        while (!op_ready) begin
            @(posedge clk);
        end
        op_valid <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // stall runs of 1 to 8 cycles plus slave latency and error knobs
    always @(posedge clk) begin : env_gen
        env_rng = xorshift(env_rng);
        if (stall_left == 0) begin
            stall      <= stall_en && (env_rng[1:0] == 2'b00);
            stall_left = int'(env_rng[4:2]);
        end else begin
            stall_left = stall_left - 1;
        end
        ar_wait    <= long_lat ? env_rng[10:8] : {1'b0, env_rng[9:8]};
        r_wait     <= long_lat ? 5'd13 + {2'b00, env_rng[14:12]} : {3'b000, env_rng[13:12]};
        inject_err <= err_en && (env_rng[20:18] == 3'b000);
    end

    always @(posedge clk) begin : monitor
        logic [RADDR_W+XLEN-1:0] exp_w;
        logic                    beat;
        logic                    busy;
        logic                    exp_slow;
        if (rst_n) begin
            beat = m_rvalid && m_rready;
            // read is out from the cycle after acceptance up to its R beat
            busy = pend_load;
            if (op_valid && op_ready) begin
                if (op_load) begin
                    pend_load  = 1'b1;
                    pend_addr  = op_c;
                    pend_width = op_width;
                    pend_we    = op_we;
                    pend_waddr = op_waddr;
                end else if (op_we) begin
                    exp_q.push_back({op_waddr, op_c});
                end
            end
            if (beat) begin
                pend_load = 1'b0;
                if (m_rresp != 2'b00) begin
                    err_exp++;
                end else if (pend_we) begin
                    exp_w = {pend_waddr, extract_load(mem_word({pend_addr[XLEN-1:2], 2'b00}),
                                                      pend_addr[1:0], pend_width)};
                    exp_q.push_back(exp_w);
                end
            end
            if (wb_we && stall) begin
                report_mismatch("write while stall is high");
            end
            if (wb_we && exp_q.size() == 0) begin
                err_cnt++;
                $display("ERROR @%0t: write to x%0d with no write outstanding", $time, wb_waddr);
            end else if (wb_we) begin
                exp_w = exp_q.pop_front();
                checked++;
                if (wb_waddr != exp_w[XLEN+:RADDR_W] || wb_data != exp_w[XLEN-1:0]) begin
                    report_mismatch($sformatf("write x%0d = %h, expected x%0d = %h", wb_waddr,
                                              wb_data, exp_w[XLEN+:RADDR_W], exp_w[XLEN-1:0]));
                end
            end
            if (load_err) begin
                err_seen++;
            end
            if (load_err != (beat && m_rresp != 2'b00)) begin
                report_mismatch($sformatf("load_err_o = %b on this cycle", load_err));
            end
            // slow flag when the read is still out after TIMEOUT cycles
            exp_slow = busy && (wait_cnt == TIMEOUT);
            if (exp_slow) begin
                slow_exp++;
            end
            if (rd_slow) begin
                slow_seen++;
            end
            if (rd_slow != exp_slow) begin
                report_mismatch($sformatf("rd_slow_o = %b, expected %b", rd_slow, exp_slow));
            end
            wait_cnt = busy ? wait_cnt + 1 : 0;
        end
    end

    initial begin
        int              i;
        int              gap;
        logic [31:0]     r1;
        logic [1:0]      wcode;
        logic [XLEN-1:0] c;
        logic            load;
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op_c     = '0;
        op_waddr = '0;
        op_we    = 1'b0;
        op_load  = 1'b0;
        op_width = '0;
        repeat (16) @(posedge clk);
        if (op_ready || wb_we || m_arvalid || m_rready || load_err || rd_slow) begin
            report_mismatch("outputs not low during reset");
        end
        rst_n <= 1'b1;
        @(posedge clk);
        if (op_ready || wb_we || m_arvalid || m_rready) begin
            report_mismatch("outputs not low after reset release");
        end
        stall_en <= 1'b1;
        for (i = 0; i < NUM_OPS; i++) begin
            if (i == ALU_OPS) begin
                err_en <= 1'b1;
            end
            if (i == LONG_AT) begin
                long_lat <= 1'b1;
            end
            op_rng = xorshift(op_rng);
            r1     = op_rng;
            op_rng = xorshift(op_rng);
            c      = op_rng;
            load   = (i >= ALU_OPS) && (r1[1:0] != 2'b00);
            wcode  = (r1[3:2] == 2'b11) ? 2'b10 : r1[3:2];
            // halves and words stay naturally aligned
            if (load && wcode == 2'b01) begin
                c[0] = 1'b0;
            end
            if (load && wcode == 2'b10) begin
                c[1:0] = 2'b00;
            end
            gap = (r1[15:14] == 2'b00) ? int'(r1[17:16]) + 1 : 0;
            repeat (gap) @(posedge clk);
            send_op(c, r1[9:5], r1[12:10] != 3'b000, load, {r1[4], wcode});
        end
        @(negedge clk);
        while (exp_q.size() != 0 || pend_load) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        if (err_seen != err_exp) begin
            report_mismatch($sformatf("%0d load errors, expected %0d", err_seen, err_exp));
        end
        if (slow_seen == 0 || err_exp == 0) begin
            err_cnt++;
            $display("ERROR: no slow read or no error response was exercised");
        end
        print_counts();
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_OPS * 40) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not complete",
                 NUM_OPS * 40);
        print_counts();
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- verilog.f
rtl/wb_pkg.sv
rtl/mem_wb_reg.sv
rtl/wb_flow_ctrl.sv
rtl/rd_wait_timer.sv
rtl/dcache_rd_port.sv
rtl/wb_stage.sv
rtl/wb_subsys_top.sv
tb/axil_mem_model.sv
tb/tb_wb_subsys.sv
